// File: sources.f
+incdir+hw
hw/vid_pkg.sv
hw/plane_if.sv
hw/video_timing.sv
hw/fb_fetch_ctrl.sv
hw/plane_shifter.sv
hw/palette_lookup.sv
hw/fb_video_top.sv
tb/fb_checker.sv
tb/tb_fb_video.sv

// File: tb/tb_fb_video.sv
// testbench top for the video pixel path, runs the palette table against a plane memory model
`timescale 1ns/10ps
`default_nettype none
`include "vid_defines.svh"

module tb_fb_video;

	localparam int ROWS        = 8;
	localparam int LINE_CLKS   = `VID_LINE_PIXELS * `VID_CLKS_PER_PIXEL;
	// two lines per table row, plus reset and drain margin
	localparam int CYCLE_LIMIT = (ROWS * 2 + 2) * LINE_CLKS;

	logic                       clk24;
	logic                       rst_n;
	logic [7:0]                 vdata80;
	logic [7:0]                 vdataa0;
	logic [7:0]                 vdatac0;
	logic [7:0]                 vdatae0;
	vid_pkg::pal_op_t           pal_op;
	logic [3:0]                 pal_idx;
	logic [7:0]                 pal_data;
	wire  [`VID_ADDR_WIDTH-1:0] sram_addr;
	wire                        rdvid;
	wire                        hsync;
	wire                        border;
	wire  [3:0]                 coloridx;
	wire  [7:0]                 rgb;
	int                         error_count;
	int                         check_count;
	int                         cycles;
	int                         cur_row;
	integer                     seed;
	logic [`VID_ADDR_WIDTH-1:0] rd_addr;

	// stimulus table, palette operation and plane pattern per row
	vid_pkg::pal_op_t tbl_op   [ROWS];
	logic [3:0]       tbl_idx  [ROWS];
	logic [7:0]       tbl_data [ROWS];
	logic [31:0]      tbl_pat  [ROWS];

	fb_video_top i_dut (
		.clk24(clk24), .rst_n(rst_n), .vdata80(vdata80), .vdataa0(vdataa0),
		.vdatac0(vdatac0), .vdatae0(vdatae0), .pal_op(pal_op), .pal_idx(pal_idx),
		.pal_data(pal_data), .sram_addr(sram_addr), .rdvid(rdvid), .hsync(hsync),
		.border(border), .coloridx(coloridx), .rgb(rgb)
	);

	fb_checker i_chk (
		.clk24(clk24), .rst_n(rst_n), .vdata80(vdata80), .vdataa0(vdataa0),
		.vdatac0(vdatac0), .vdatae0(vdatae0), .pal_op(pal_op), .pal_idx(pal_idx),
		.pal_data(pal_data), .sram_addr(sram_addr), .rdvid(rdvid), .hsync(hsync),
		.border(border), .coloridx(coloridx), .rgb(rgb),
		.error_count(error_count), .check_count(check_count)
	);

	always #5 clk24 = ~clk24;

	// plane byte from the whole address, rotated high byte per plane
	function automatic logic [7:0] plane_fill(input logic [15:0] addr, input logic [31:0] pat,
		input int plane);
		logic [15:0] rot;
		rot = {addr[15:8], addr[15:8]} >> plane;
		return pat[8*plane +: 8] ^ addr[7:0] ^ rot[7:0];
	endfunction

	task automatic set_row(input int r, input vid_pkg::pal_op_t op, input logic [3:0] idx,
		input logic [7:0] data, input logic [31:0] base);
		tbl_op[r]   = op;
		tbl_idx[r]  = idx;
		tbl_data[r] = data;
		tbl_pat[r]  = base ^ $random(seed);
	endtask

	task automatic wait_line_starts(input int n);
		int   seen;
		logic prev;
		seen = 0;
		prev = hsync;
		while (seen < n) begin
			@(posedge clk24);
			if (prev && !hsync)
				seen++;
			prev = hsync;
		end
	endtask

	// ----------------------------------------------------------
	// video memory, answers each read strobe
	// ----------------------------------------------------------
	always @(posedge clk24) begin
		if (rst_n && rdvid) begin
			rd_addr = sram_addr;
			vdata80 <= plane_fill(rd_addr, tbl_pat[cur_row], 3);
			vdataa0 <= plane_fill(rd_addr, tbl_pat[cur_row], 2);
			vdatac0 <= plane_fill(rd_addr, tbl_pat[cur_row], 1);
			vdatae0 <= plane_fill(rd_addr, tbl_pat[cur_row], 0);
		end
	end

	// watchdog
	always @(posedge clk24) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not complete within %0d clocks", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		clk24    = 1'b0;
		rst_n    = 1'b0;
		vdata80  = 8'd0;
		vdataa0  = 8'd0;
		vdatac0  = 8'd0;
		vdatae0  = 8'd0;
		pal_op   = vid_pkg::PAL_NOP;
		pal_idx  = 4'd0;
		pal_data = 8'd0;
		cur_row  = 0;
		cycles   = 0;
		seed     = 32'hb7bb_530d;
		set_row(0, vid_pkg::PAL_WRITE,  4'h0, 8'h92, 32'h0f0f_3c3c);
		set_row(1, vid_pkg::PAL_WRITE,  4'h7, 8'h5b, 32'ha5a5_0ff0);
		set_row(2, vid_pkg::PAL_BORDER, 4'h7, 8'h00, 32'h1234_8765);
		set_row(3, vid_pkg::PAL_WRITE,  4'hc, 8'he3, 32'hff00_00ff);
		set_row(4, vid_pkg::PAL_WRITE,  4'h7, 8'h24, 32'h5555_aaaa);
		set_row(5, vid_pkg::PAL_BORDER, 4'hc, 8'h00, 32'hc3c3_9696);
		set_row(6, vid_pkg::PAL_NOP,    4'h0, 8'h00, 32'h0000_ffff);
		set_row(7, vid_pkg::PAL_WRITE,  4'h5, 8'hff, 32'h7e81_18e7);
		repeat (2) @(posedge clk24);
		rst_n <= 1'b1;
		// one palette operation, then two lines with this row's pattern
		for (int r = 0; r < ROWS; r++) begin
			@(posedge clk24);
			cur_row  <= r;
			pal_op   <= tbl_op[r];
			pal_idx  <= tbl_idx[r];
			pal_data <= tbl_data[r];
			@(posedge clk24);
			pal_op <= vid_pkg::PAL_NOP;
			wait_line_starts(2);
		end
		@(posedge clk24);
		i_chk.print_counts();
		if (error_count == 0 && check_count > 0) begin
			$display("Verification passed");
		end else begin
			if (check_count == 0)
				$display("no checks were made, the DUT showed no activity");
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/fb_checker.sv
// watcher for the video pixel path, instantiated by the testbench to compare and count errors
`timescale 1ns/10ps
`default_nettype none
`include "vid_defines.svh"

module fb_checker (
	input  wire                        clk24,
	input  wire                        rst_n,
	input  wire  [7:0]                 vdata80,
	input  wire  [7:0]                 vdataa0,
	input  wire  [7:0]                 vdatac0,
	input  wire  [7:0]                 vdatae0,
	input  vid_pkg::pal_op_t           pal_op,
	input  wire  [3:0]                 pal_idx,
	input  wire  [7:0]                 pal_data,
	input  wire  [`VID_ADDR_WIDTH-1:0] sram_addr,
	input  wire                        rdvid,
	input  wire                        hsync,
	input  wire                        border,
	input  wire  [3:0]                 coloridx,
	input  wire  [7:0]                 rgb,
	output int                         error_count,
	output int                         check_count
);

	// 8 pixels per fetch group
	localparam int GROUP_CLKS      = 8 * `VID_CLKS_PER_PIXEL;
	localparam int GROUPS_PER_LINE = `VID_LINE_PIXELS / 8;
	localparam int HSYNC_CLKS      = `VID_HSYNC_PIXELS * `VID_CLKS_PER_PIXEL;

	// palette model as the cpu port left it
	logic [7:0]  pal_m [16];
	logic [3:0]  bidx_m;
	logic [7:0]  rgb_exp;
	// plane bytes {80, a0, c0, e0}, latched at load and being shifted
	logic [31:0] loaded;
	logic [31:0] active;
	logic [8:0]  row;
	logic        hsync_q;
	logic [4:0]  col_cur;
	logic [4:0]  col_exp;
	logic        reload_cur;
	// border flag at fetch time and its two pixel delay
	logic        fetch_m;
	logic [1:0]  dly_m;
	logic [3:0]  idx_exp;
	// colour index as the shifter should be holding it
	logic [3:0]  idx_m;
	bit          rd_seen;
	bit          hs_seen;
	int          since_rd;
	int          rd_in_line;
	int          low_clks;
	int          rst_edges;
	int          pulses;
	int          pixels;
	int          k;

	task automatic report(input string msg);
		error_count++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	task print_counts();
		$display("checks: rdvid %0d, pixels %0d, total %0d, errors %0d",
			pulses, pixels, check_count, error_count);
	endtask

	initial begin
		error_count = 0;
		check_count = 0;
		rst_edges   = 0;
		pulses      = 0;
		pixels      = 0;
	end

	always @(posedge clk24) begin
		if (!rst_n) begin
			rst_edges++;
			// DUT registers hold reset values after the first reset edge
			if (rst_edges > 1) begin
				check_count++;
				if (rdvid !== 1'b0 || rgb !== 8'd0)
					report($sformatf("rdvid %b rgb %h during reset, expected 0 and 00",
						rdvid, rgb));
			end
			for (int i = 0; i < 16; i++)
				pal_m[i] = 8'd0;
			bidx_m     = 4'd0;
			rgb_exp    = 8'd0;
			loaded     = 32'd0;
			active     = 32'd0;
			row        = 9'd0;
			hsync_q    = 1'b0;
			col_cur    = 5'd0;
			reload_cur = 1'b0;
			fetch_m    = 1'b1;
			dly_m      = 2'b11;
			idx_m      = 4'd0;
			rd_seen    = 1'b0;
			hs_seen    = 1'b0;
			since_rd   = 0;
			rd_in_line = 0;
			low_clks   = 0;
		end else begin
			// ----------------------------------------------------------
			// line start, one row per hsync fall
			// ----------------------------------------------------------
			if (hsync_q && !hsync) begin
				check_count++;
				if (rd_in_line != GROUPS_PER_LINE)
					report($sformatf("%0d rdvid pulses in line, expected %0d",
						rd_in_line, GROUPS_PER_LINE));
				rd_in_line = 0;
				row = (row == 9'(`VID_FB_ROWS - 1)) ? 9'd0 : row + 9'd1;
				hs_seen  = 1'b1;
				low_clks = 0;
			end
			// sync pulse width, measured from a full line start
			if (hs_seen && !hsync_q && hsync) begin
				check_count++;
				if (low_clks != HSYNC_CLKS)
					report($sformatf("hsync low for %0d clocks, expected %0d",
						low_clks, HSYNC_CLKS));
			end
			hsync_q = hsync;
			if (!hsync)
				low_clks++;

			// ----------------------------------------------------------
			// read strobe and address
			// ----------------------------------------------------------
			since_rd++;
			if (rdvid) begin
				pulses++;
				check_count++;
				rd_in_line++;
				if (rd_seen && since_rd != GROUP_CLKS)
					report($sformatf("rdvid after %0d clocks, expected %0d", since_rd, GROUP_CLKS));
				// column starts at 0, steps by one, reloads after odd row sync
				col_exp = !rd_seen ? 5'd0 : reload_cur ? 5'(`VID_COLUMN_START) : col_cur + 5'd1;
				if (sram_addr !== {1'(`VID_ADDR_BASE), 2'b00, col_exp, row[8:1]})
					report($sformatf("sram_addr %h, expected column %0d row field %h",
						sram_addr, col_exp, row[8:1]));
				col_cur    = sram_addr[12:8];
				reload_cur = !hsync && row[0];
				active     = loaded;
				rd_seen    = 1'b1;
				since_rd   = 0;
			end
			// memory bytes must be valid by the load, 4 clocks after rdvid
			if (since_rd == 4)
				loaded = {vdata80, vdataa0, vdatac0, vdatae0};

			// ----------------------------------------------------------
			// colour index and border, one clock after each pixel enable
			// ----------------------------------------------------------
			if (rd_seen && since_rd < GROUP_CLKS && since_rd % `VID_CLKS_PER_PIXEL == 2) begin
				k = since_rd / `VID_CLKS_PER_PIXEL;
				idx_exp = {active[31-k], active[23-k], active[15-k], active[7-k]};
				pixels++;
				check_count++;
				if (coloridx !== idx_exp)
					report($sformatf("coloridx %h at pixel %0d, expected %h", coloridx, k, idx_exp));
				idx_m = idx_exp;
				// column step lands before the fourth pixel enable
				if (k == 3) begin
					if (col_cur == 5'd0)
						fetch_m = ~fetch_m;
					else if (reload_cur)
						fetch_m = 1'b1;
				end
				dly_m = {fetch_m, dly_m[1]};
				if (border !== dly_m[0])
					report($sformatf("border %b at pixel %0d, expected %b", border, k, dly_m[0]));
			end

			// ----------------------------------------------------------
			// palette output, registered one clock after its inputs
			// ----------------------------------------------------------
			check_count++;
			if (rgb !== rgb_exp)
				report($sformatf("rgb %h, expected %h", rgb, rgb_exp));
			// lookup sees the palette from before a same clock write
			rgb_exp = pal_m[dly_m[0] ? bidx_m : idx_m];
			case (pal_op)
				vid_pkg::PAL_WRITE:  pal_m[pal_idx] = pal_data;
				vid_pkg::PAL_BORDER: bidx_m = pal_idx;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/fb_video_top.sv
// top level of the video pixel path, wiring timing, fetch, shifter and palette to plain ports
`timescale 1ns/10ps
`default_nettype none
`include "vid_defines.svh"

module fb_video_top (
	input  wire                        clk24,
	input  wire                        rst_n,
	input  wire  [7:0]                 vdata80,
	input  wire  [7:0]                 vdataa0,
	input  wire  [7:0]                 vdatac0,
	input  wire  [7:0]                 vdatae0,
	input  vid_pkg::pal_op_t           pal_op,
	input  wire  [3:0]                 pal_idx,
	input  wire  [7:0]                 pal_data,
	output logic [`VID_ADDR_WIDTH-1:0] sram_addr,
	output logic                       rdvid,
	output logic                       hsync,
	output logic                       border,
	output logic [3:0]                 coloridx,
	output logic [7:0]                 rgb
);

	logic       ce12;
	logic       ce_pixel;
	logic       video_slice;
	logic       pipe_abx;
	logic [8:0] fb_row;

	plane_if pif ();

	// memory bytes go straight onto the plane bundle
	assign pif.d80 = vdata80;
	assign pif.da0 = vdataa0;
	assign pif.dc0 = vdatac0;
	assign pif.de0 = vdatae0;

	// ----------------------------------------------------------
	// blocks
	// ----------------------------------------------------------
	video_timing u_timing (
		.clk24(clk24), .rst_n(rst_n), .ce12(ce12), .ce_pixel(ce_pixel),
		.video_slice(video_slice), .pipe_abx(pipe_abx), .hsync(hsync), .fb_row(fb_row)
	);

	fb_fetch_ctrl u_fetch (
		.clk24(clk24), .rst_n(rst_n), .ce12(ce12), .video_slice(video_slice),
		.pipe_abx(pipe_abx), .hsync(hsync), .fb_row(fb_row), .ce_pixel(ce_pixel),
		.sram_addr(sram_addr), .rdvid(rdvid), .border(border), .pif(pif.fetch)
	);

	plane_shifter u_shifter (
		.clk24(clk24), .rst_n(rst_n), .pif(pif.shift), .coloridx(coloridx)
	);

	// border flag is already pixel aligned
	palette_lookup u_palette (
		.clk24(clk24), .rst_n(rst_n), .coloridx(coloridx), .border(border),
		.pal_op(pal_op), .pal_idx(pal_idx), .pal_data(pal_data), .rgb(rgb)
	);

endmodule

`default_nettype wire

// File: hw/palette_lookup.sv
// cpu writable 16-entry palette with border colour select and registered rgb output
`timescale 1ns/10ps
`default_nettype none

module palette_lookup (
	input  wire             clk24,
	input  wire             rst_n,
	input  wire  [3:0]      coloridx,
	input  wire             border,
	input  vid_pkg::pal_op_t pal_op,
	input  wire  [3:0]      pal_idx,
	input  wire  [7:0]      pal_data,
	output logic [7:0]      rgb
);

	// palette entries, packed rgb per index
	logic [7:0] pal_mem [16];
	// palette index used while in the border
	logic [3:0] border_idx;
	logic [3:0] rd_idx;

	// border overrides the pixel index
	assign rd_idx = border ? border_idx : coloridx;

	// ----------------------------------------------------------
	// cpu port and lookup
	// ----------------------------------------------------------
	always_ff @(posedge clk24) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				pal_mem[i] <= 8'd0;
			border_idx <= 4'd0;
			rgb        <= 8'd0;
		end else begin
			case (pal_op)
				vid_pkg::PAL_WRITE:  pal_mem[pal_idx] <= pal_data;
				vid_pkg::PAL_BORDER: border_idx <= pal_idx;
				default: ;
			endcase
			// read sees the entry from before a same clock write
			rgb <= pal_mem[rd_idx];
		end
	end

endmodule

`default_nettype wire

// File: hw/plane_shifter.sv
// four ping-pong shift register pairs turning plane bytes into a 4-bit colour index
`timescale 1ns/10ps
`default_nettype none

module plane_shifter (
	input  wire        clk24,
	input  wire        rst_n,
	plane_if.shift     pif,
	output logic [3:0] coloridx
);

	// plane bytes in plane order, 80 plane at index 0
	logic [7:0] plane_byte [4];
	// msb of the active register of each plane
	logic [3:0] plane_bit;

	assign plane_byte[0] = pif.d80;
	assign plane_byte[1] = pif.da0;
	assign plane_byte[2] = pif.dc0;
	assign plane_byte[3] = pif.de0;

	// ----------------------------------------------------------
	// one register pair per plane
	// ----------------------------------------------------------
	for (genvar p = 0; p < 4; p++) begin : g_plane
		logic [7:0] sh_a;
		logic [7:0] sh_b;

		// pipe_sel high, b shifts and a takes the next byte
		always_ff @(posedge clk24) begin
			if (!rst_n) begin
				sh_a <= 8'd0;
				sh_b <= 8'd0;
			end else if (pif.pipe_sel) begin
				if (pif.load)
					sh_a <= plane_byte[p];
				if (pif.ce_pixel)
					sh_b <= {sh_b[6:0], 1'b0};
			end else begin
				if (pif.load)
					sh_b <= plane_byte[p];
				if (pif.ce_pixel)
					sh_a <= {sh_a[6:0], 1'b0};
			end
		end

		// 80 plane ends up as bit 3
		assign plane_bit[3-p] = pif.pipe_sel ? sh_b[7] : sh_a[7];
	end

	// sample on the pixel enable so the index ignores the select edge
	always_ff @(posedge clk24) begin
		if (!rst_n)
			coloridx <= 4'd0;
		else if (pif.ce_pixel)
			coloridx <= plane_bit;
	end

endmodule

`default_nettype wire

// File: hw/fb_fetch_ctrl.sv
// fetch controller walking byte columns, driving the video address, read strobe and plane loads
`timescale 1ns/10ps
`default_nettype none
`include "vid_defines.svh"

module fb_fetch_ctrl (
	input  wire                          clk24,
	input  wire                          rst_n,
	input  wire                          ce12,
	input  wire                          video_slice,
	input  wire                          pipe_abx,
	input  wire                          hsync,
	input  wire  [8:0]                   fb_row,
	input  wire                          ce_pixel,
	output logic [`VID_ADDR_WIDTH-1:0]   sram_addr,
	output logic                         rdvid,
	output logic                         border,
	plane_if.fetch                       pif
);

	// fetch phase, also the page of the current step
	vid_pkg::fetch_phase_t ax;
	// byte column within the line
	logic [4:0] column;
	// border flag at fetch time
	logic       border_fetch;
	// two pixel delay to line up with shifter output
	logic [1:0] border_dly;
	logic       fetch_step;
	logic       load_q;
	vid_pkg::sync_state_t line_sync;

	// step on the ce12 clock between pixel enables, inside the slice
	assign fetch_step = video_slice & ce12 & ~ce_pixel;

	// hsync level read back as a sync state
	assign line_sync = vid_pkg::sync_state_t'(hsync);

	// ----------------------------------------------------------
	// phase, column and strobes
	// ----------------------------------------------------------
	always_ff @(posedge clk24) begin
		if (!rst_n) begin
			ax           <= vid_pkg::PH_READ;
			column       <= 5'd0;
			border_fetch <= 1'b1;
			rdvid        <= 1'b0;
			load_q       <= 1'b0;
		end else if (fetch_step) begin
			ax     <= vid_pkg::fetch_phase_t'(ax + 2'd1);
			// strobes land on the clock after their step
			rdvid  <= (ax == vid_pkg::PH_READ);
			load_q <= (ax == pif.LOAD_PHASE);
			if (ax == vid_pkg::PH_STEP) begin
				// odd rows in sync restart the line at the left border
				if (line_sync == vid_pkg::SYNC_PULSE && fb_row[0]) begin
					column       <= 5'(`VID_COLUMN_START);
					border_fetch <= 1'b1;
				end else begin
					column <= column + 5'd1;
				end
				// wrap through zero flips between border and picture
				if (column == 5'd0)
					border_fetch <= ~border_fetch;
			end
		end else begin
			rdvid  <= 1'b0;
			load_q <= 1'b0;
		end
	end

	// address follows each step, row field is the upper row bits
	always_ff @(posedge clk24) begin
		if (fetch_step)
			sram_addr <= {1'(`VID_ADDR_BASE), 2'b00, column, fb_row[8:1]};
	end

	// border delay runs at pixel rate
	always_ff @(posedge clk24) begin
		if (!rst_n)
			border_dly <= 2'b11;
		else if (ce_pixel)
			border_dly <= {border_fetch, border_dly[1]};
	end

	assign border = border_dly[0];

	// shift controls toward the plane shifter
	assign pif.load     = load_q;
	assign pif.pipe_sel = pipe_abx;
	assign pif.ce_pixel = ce_pixel;

endmodule

`default_nettype wire

// File: hw/video_timing.sv
// clock enable, fetch slice, ping-pong select, hsync and row generator for the pixel path
`timescale 1ns/10ps
`default_nettype none
`include "vid_defines.svh"

module video_timing (
	input  wire        clk24,
	input  wire        rst_n,
	output logic       ce12,
	output logic       ce_pixel,
	output logic       video_slice,
	output logic       pipe_abx,
	output logic       hsync,
	output logic [8:0] fb_row
);

	// clock divider, one pixel per full count
	logic [1:0] clk_div;
	// pixel position within an 8 pixel group
	logic [2:0] grp_pix;
	// pixel position within the line
	logic [9:0] line_pix;
	logic [9:0] line_pix_next;
	logic       line_end;
	vid_pkg::sync_state_t sync_state;

	// ----------------------------------------------------------
	// enables
	// ----------------------------------------------------------
	// ce12 on odd divider counts, ce_pixel on the last one
	assign ce12     = clk_div[0];
	assign ce_pixel = (clk_div == 2'(`VID_CLKS_PER_PIXEL - 1));

	// first four pixels of a group, 16 clocks, four fetch steps
	assign video_slice = ~grp_pix[2];

	assign line_end      = (line_pix == 10'(`VID_LINE_PIXELS - 1));
	assign line_pix_next = line_end ? 10'd0 : line_pix + 10'd1;

	assign hsync = (sync_state == vid_pkg::SYNC_ACTIVE);

	always_ff @(posedge clk24) begin
		if (!rst_n) begin
			clk_div    <= 2'd0;
			grp_pix    <= 3'd0;
			line_pix   <= 10'd0;
			pipe_abx   <= 1'b0;
			sync_state <= vid_pkg::SYNC_PULSE;
			fb_row     <= 9'd0;
		end else begin
			clk_div <= clk_div + 2'd1;
			if (ce_pixel) begin
				grp_pix  <= grp_pix + 3'd1;
				line_pix <= line_pix_next;
				// new value shows on the first clock of the next group
				if (grp_pix == 3'd7)
					pipe_abx <= ~pipe_abx;
				// sync low during the first pixels of each line
				if (line_pix_next < 10'(`VID_HSYNC_PIXELS))
					sync_state <= vid_pkg::SYNC_PULSE;
				else
					sync_state <= vid_pkg::SYNC_ACTIVE;
				if (line_end)
					fb_row <= (fb_row == 9'(`VID_FB_ROWS - 1)) ? 9'd0 : fb_row + 9'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/plane_if.sv
// plane byte and shift control bundle between the fetch controller and the plane shifter
`timescale 1ns/10ps
`default_nettype none

interface plane_if;

	// phase whose step produces the load pulse
	localparam vid_pkg::fetch_phase_t LOAD_PHASE = vid_pkg::PH_LOAD;

	// plane bytes from video memory, 80 plane first
	logic [7:0] d80;
	logic [7:0] da0;
	logic [7:0] dc0;
	logic [7:0] de0;

	// one clock load pulse, bytes go into the idle register
	logic load;
	// ping-pong select, picks which register shifts
	logic pipe_sel;
	// pixel enable for shifting
	logic ce_pixel;

	modport fetch (output load, output pipe_sel, output ce_pixel);

	modport shift (input d80, input da0, input dc0, input de0,
		input load, input pipe_sel, input ce_pixel);

endinterface

`default_nettype wire

// File: hw/vid_pkg.sv
// shared enum types for the video pixel path, referenced by scoped name
`default_nettype none

package vid_pkg;

	// ----------------------------------------------------------
	// fetch phase, one per fetch step within a group
	// ----------------------------------------------------------
	// also the video page number of the plane being fetched
	typedef enum logic [1:0] {
		PH_READ  = 2'b00,
		PH_LOAD  = 2'b01,
		PH_IDLE2 = 2'b10,
		PH_STEP  = 2'b11
	} fetch_phase_t;

	// horizontal sync state
	// encoded so the value equals the hsync level
	typedef enum logic {
		SYNC_PULSE  = 1'b0,
		SYNC_ACTIVE = 1'b1
	} sync_state_t;

	// opcode of the cpu palette port
	typedef enum logic [1:0] {
		PAL_NOP    = 2'b00,
		PAL_WRITE  = 2'b01,
		PAL_BORDER = 2'b10
	} pal_op_t;

endpackage

`default_nettype wire

// File: hw/vid_defines.svh
// timing geometry and address layout macros for the video pixel path, include where needed
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// ----------------------------------------------------------
// pixel clock and line geometry
// ----------------------------------------------------------

// system clocks per pixel time, 24 MHz down to 6 MHz
`define VID_CLKS_PER_PIXEL 4

// pixel times per full line, sync included
`define VID_LINE_PIXELS 768

// hsync low for this many pixel times at line start
`define VID_HSYNC_PIXELS 56

// frame buffer rows per frame, fb_row wraps here
`define VID_FB_ROWS 312

// ----------------------------------------------------------
// video memory address layout
// ----------------------------------------------------------

// column counter reload value after hsync on odd rows
`define VID_COLUMN_START 26

// top address bit, selects the upper 32k video area
`define VID_ADDR_BASE 1

// video memory address width
`define VID_ADDR_WIDTH 16

`endif
